//--- hdl/nes_glue_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared constants for the NES glue logic
// UART register map, memory phase numbers and controller bit positions
// DualShock bytes are active low as they come from the controller engine
////////////////////////////////////////////////////////////////////////////
package nes_glue_pkg;

  // UART register map
  localparam logic [7:0] REG_LOADER_CONF = 8'h35;  // bit 0 holds loader in reset
  localparam logic [7:0] REG_LOADER_DATA = 8'h37;
  localparam logic [7:0] REG_BTN_P1      = 8'h40;
  localparam logic [7:0] REG_BTN_P2      = 8'h41;

  localparam int MEM_ADDR_W = 22;  // 4MB space
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

  typedef logic [2:0] phase_t;
  localparam phase_t PHASE_LAST = 3'd4;
  localparam phase_t PHASE_MEM  = 3'd0;  // console commands reach memory
  localparam phase_t PHASE_NES  = 3'd4;  // console clock enable

  // NES button byte, as the console shifts it out (A first)
  localparam int BTN_A      = 0;
  localparam int BTN_B      = 1;
  localparam int BTN_SELECT = 2;
  localparam int BTN_START  = 3;
  localparam int BTN_UP     = 4;
  localparam int BTN_DOWN   = 5;
  localparam int BTN_LEFT   = 6;
  localparam int BTN_RIGHT  = 7;

  // dualshock byte 0
  localparam int DS_SELECT = 0;
  localparam int DS_START  = 3;
  localparam int DS_UP     = 4;
  localparam int DS_RIGHT  = 5;
  localparam int DS_DOWN   = 6;
  localparam int DS_LEFT   = 7;
  // dualshock byte 1, shape buttons only
  localparam int DS_TRIANGLE = 4;
  localparam int DS_CIRCLE   = 5;
  localparam int DS_CROSS    = 6;
  localparam int DS_SQUARE   = 7;

endpackage

//--- hdl/uart_reg_decoder.sv
////////////////////////////////////////////////////////////////////////////
// register writes from the UART demux, one strobe per byte
// loader bytes pass through in the cycle of the write, no buffering
// only bit 0 of the loader configuration register is kept
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_reg_decoder import nes_glue_pkg::*; (
  input  logic       clk,
  input  logic       sys_resetn,
  input  logic [7:0] uart_data,
  input  logic [7:0] uart_addr,
  input  logic       uart_write,
  output logic [7:0] loader_byte,
  output logic       loader_byte_valid,
  output logic       loader_reset,
  output logic [7:0] remote_btn1,
  output logic [7:0] remote_btn2
);

  logic loader_hold;  // config bit 0

  logic wr_conf;
  logic wr_btn1;
  logic wr_btn2;

  assign wr_conf = uart_write && (uart_addr == REG_LOADER_CONF);
  assign wr_btn1 = uart_write && (uart_addr == REG_BTN_P1);
  assign wr_btn2 = uart_write && (uart_addr == REG_BTN_P2);

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      loader_hold <= 1'b0;
      remote_btn1 <= '0;
      remote_btn2 <= '0;
    end else begin
      if (wr_conf) loader_hold <= uart_data[0];
      if (wr_btn1) remote_btn1 <= uart_data;
      if (wr_btn2) remote_btn2 <= uart_data;
    end
  end

  // ROM stream goes straight to the loader
  assign loader_byte       = uart_data;
  assign loader_byte_valid = uart_write && (uart_addr == REG_LOADER_DATA);

  // loader also sits in reset with the system
  assign loader_reset = !sys_resetn || loader_hold;

endmodule

//--- hdl/autofire.sv
////////////////////////////////////////////////////////////////////////////
// square wave while a button is held, half period AUTOFIRE_HALF clocks
// first rise AUTOFIRE_HALF edges after the button is seen
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module autofire #(
  parameter int AUTOFIRE_HALF = 4
) (
  input  logic clk,
  input  logic sys_resetn,
  input  logic btn,
  output logic out
);

  localparam int CNT_W = $clog2(AUTOFIRE_HALF + 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      cnt <= '0;
      out <= 1'b0;
    end else if (!btn) begin
      // released, start over next press
      cnt <= '0;
      out <= 1'b0;
    end else if (cnt == CNT_W'(AUTOFIRE_HALF - 1)) begin
      cnt <= '0;
      out <= !out;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- hdl/pad_mapper.sv
////////////////////////////////////////////////////////////////////////////
// one player's button merge into NES order
// DualShock bytes are active low, USB and remote bytes active high
// triangle and USB X fire A, square and USB Y fire B
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module pad_mapper import nes_glue_pkg::*; #(
  parameter int AUTOFIRE_HALF = 4
) (
  input  logic       clk,
  input  logic       sys_resetn,
  input  logic [7:0] ds_b0,
  input  logic [7:0] ds_b1,
  input  logic [7:0] usb_btn,
  input  logic       usb_x,
  input  logic       usb_y,
  input  logic [7:0] remote_btn,
  output logic [7:0] nes_btn
);

  logic tri_held;
  logic sq_held;
  logic fire_a;    // from triangle
  logic fire_b;    // from square
  logic [7:0] ds_btn;

  assign tri_held = !ds_b1[DS_TRIANGLE] || usb_x;
  assign sq_held  = !ds_b1[DS_SQUARE] || usb_y;

  autofire #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) u_af_triangle (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .btn        (tri_held),
    .out        (fire_a)
  );

  autofire #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) u_af_square (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .btn        (sq_held),
    .out        (fire_b)
  );

  always_comb begin
    ds_btn             = '0;
    ds_btn[BTN_A]      = !ds_b1[DS_CIRCLE] || fire_a;
    ds_btn[BTN_B]      = !ds_b1[DS_CROSS] || fire_b;
    ds_btn[BTN_SELECT] = !ds_b0[DS_SELECT];
    ds_btn[BTN_START]  = !ds_b0[DS_START];
    ds_btn[BTN_UP]     = !ds_b0[DS_UP];
    ds_btn[BTN_DOWN]   = !ds_b0[DS_DOWN];
    ds_btn[BTN_LEFT]   = !ds_b0[DS_LEFT];
    ds_btn[BTN_RIGHT]  = !ds_b0[DS_RIGHT];
  end

  // any source presses the button
  assign nes_btn = ds_btn | usb_btn | remote_btn;

endmodule

//--- hdl/joypad_shift.sv
////////////////////////////////////////////////////////////////////////////
// console joypad port, parallel load on strobe and serial out on bit 0
// shift lands one edge after the low sample of the joypad clock
// a shift in the same cycle as a strobe wins
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module joypad_shift import nes_glue_pkg::*; (
  input  logic       clk,
  input  logic       sys_resetn,
  input  logic [7:0] buttons,
  input  logic       strobe,
  input  logic       joy_clk,
  output logic       joy_data
);

  logic [7:0] latch;
  logic       joy_clk_q;
  logic       fall_q;     // registered falling edge

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      joy_clk_q <= 1'b0;
      fall_q    <= 1'b0;
    end else begin
      joy_clk_q <= joy_clk;
      fall_q    <= joy_clk_q && !joy_clk;
    end
  end

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      latch <= '0;
    end else if (fall_q) begin
      latch <= {1'b0, latch[7:1]};  // zero fills from the top
    end else if (strobe) begin
      latch <= buttons;
    end
  end

  assign joy_data = latch[BTN_A];

endmodule

//--- hdl/nes_phase_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// five phase sequencer, console runs on PHASE_NES and its memory
// command is let through on PHASE_MEM right after
// loader writes win at any phase, there is no back-pressure
// console is held in reset until loader_done
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module nes_phase_arbiter import nes_glue_pkg::*; (
  input  logic       clk,
  input  logic       sys_resetn,
  input  logic       loader_done,
  // console side
  input  logic       nes_read_cpu,
  input  logic       nes_read_ppu,
  input  logic       nes_write,
  input  mem_addr_t  nes_addr,
  input  logic [7:0] nes_wdata,
  // loader side
  input  logic       loader_write,
  input  mem_addr_t  loader_addr,
  input  logic [7:0] loader_wdata,
  input  logic       loader_refresh,
  // to console and memory controller
  output logic       nes_run,
  output logic       nes_reset,
  output logic       mem_read_a,
  output logic       mem_read_b,
  output logic       mem_write,
  output logic       mem_refresh,
  output mem_addr_t  mem_addr,
  output logic [7:0] mem_wdata
);

  phase_t phase;

  logic run_mem;     // console command slot
  logic nes_cmd;     // console wants memory
  logic mem_idle;

  // phase keeps counting through loader time
  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      phase <= PHASE_MEM;
    end else if (phase == PHASE_LAST) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  //   phase  | 0 | 1 | 2 | 3 | 4 | 0 |
  //   memory |cmd|   |   |   |   |cmd|
  //   nes                    |run|
  assign nes_reset = !loader_done;
  assign nes_run   = (phase == PHASE_NES) && loader_done;
  assign run_mem   = (phase == PHASE_MEM) && loader_done;

  assign nes_cmd  = nes_read_cpu || nes_read_ppu || nes_write;
  assign mem_idle = run_mem && !nes_cmd && !loader_write;

  // console commands only in their slot
  assign mem_read_a = run_mem && nes_read_cpu;
  assign mem_read_b = run_mem && nes_read_ppu;
  assign mem_write  = (run_mem && nes_write) || loader_write;

  // an unused slot becomes a refresh, as does a loader request
  // that does not clash with its own write
  assign mem_refresh = mem_idle || (loader_refresh && !loader_write);

  // loader owns the address and data mux when it writes
  always_comb begin
    if (loader_write) begin
      mem_addr  = loader_addr;
      mem_wdata = loader_wdata;
    end else begin
      mem_addr  = nes_addr;
      mem_wdata = nes_wdata;
    end
  end

endmodule

//--- hdl/nes_glue_top.sv
////////////////////////////////////////////////////////////////////////////
// NES console glue, sits between the console core, the memory controller
// and the ROM loader; sys_resetn must already be synchronous and clean
// controller bytes arrive decoded from their protocol engines
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module nes_glue_top import nes_glue_pkg::*; #(
  parameter int AUTOFIRE_HALF = 4
) (
  input  logic       clk,
  input  logic       sys_resetn,
  // UART demux
  input  logic [7:0] uart_data,
  input  logic [7:0] uart_addr,
  input  logic       uart_write,
  // ROM loader
  input  logic       loader_done,
  input  logic       loader_write,
  input  mem_addr_t  loader_addr,
  input  logic [7:0] loader_wdata,
  input  logic       loader_refresh,
  // controllers
  input  logic [7:0] ds1_b0,
  input  logic [7:0] ds1_b1,
  input  logic [7:0] ds2_b0,
  input  logic [7:0] ds2_b1,
  input  logic [7:0] usb1_btn,
  input  logic [7:0] usb2_btn,
  input  logic       usb1_x,
  input  logic       usb1_y,
  input  logic       usb2_x,
  input  logic       usb2_y,
  // console
  input  logic       joypad_strobe,
  input  logic [1:0] joypad_clock,
  input  logic       nes_read_cpu,
  input  logic       nes_read_ppu,
  input  logic       nes_write,
  input  mem_addr_t  nes_addr,
  input  logic [7:0] nes_wdata,
  // outputs
  output logic [7:0] loader_byte,
  output logic       loader_byte_valid,
  output logic       loader_reset,
  output logic [1:0] joypad_data,
  output logic       nes_run,
  output logic       nes_reset,
  output logic       mem_read_a,
  output logic       mem_read_b,
  output logic       mem_write,
  output logic       mem_refresh,
  output mem_addr_t  mem_addr,
  output logic [7:0] mem_wdata
);

  logic [7:0] remote_btn1;
  logic [7:0] remote_btn2;
  logic [7:0] nes_btn1;
  logic [7:0] nes_btn2;

  uart_reg_decoder u_uart_dec (
    .clk               (clk),
    .sys_resetn        (sys_resetn),
    .uart_data         (uart_data),
    .uart_addr         (uart_addr),
    .uart_write        (uart_write),
    .loader_byte       (loader_byte),
    .loader_byte_valid (loader_byte_valid),
    .loader_reset      (loader_reset),
    .remote_btn1       (remote_btn1),
    .remote_btn2       (remote_btn2)
  );

  pad_mapper #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) u_pad1 (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .ds_b0      (ds1_b0),
    .ds_b1      (ds1_b1),
    .usb_btn    (usb1_btn),
    .usb_x      (usb1_x),
    .usb_y      (usb1_y),
    .remote_btn (remote_btn1),
    .nes_btn    (nes_btn1)
  );

  pad_mapper #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) u_pad2 (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .ds_b0      (ds2_b0),
    .ds_b1      (ds2_b1),
    .usb_btn    (usb2_btn),
    .usb_x      (usb2_x),
    .usb_y      (usb2_y),
    .remote_btn (remote_btn2),
    .nes_btn    (nes_btn2)
  );

  // both ports share the strobe, each has its own clock
  joypad_shift u_joy1 (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .buttons    (nes_btn1),
    .strobe     (joypad_strobe),
    .joy_clk    (joypad_clock[0]),
    .joy_data   (joypad_data[0])
  );

  joypad_shift u_joy2 (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .buttons    (nes_btn2),
    .strobe     (joypad_strobe),
    .joy_clk    (joypad_clock[1]),
    .joy_data   (joypad_data[1])
  );

  nes_phase_arbiter u_arb (
    .clk            (clk),
    .sys_resetn     (sys_resetn),
    .loader_done    (loader_done),
    .nes_read_cpu   (nes_read_cpu),
    .nes_read_ppu   (nes_read_ppu),
    .nes_write      (nes_write),
    .nes_addr       (nes_addr),
    .nes_wdata      (nes_wdata),
    .loader_write   (loader_write),
    .loader_addr    (loader_addr),
    .loader_wdata   (loader_wdata),
    .loader_refresh (loader_refresh),
    .nes_run        (nes_run),
    .nes_reset      (nes_reset),
    .mem_read_a     (mem_read_a),
    .mem_read_b     (mem_read_b),
    .mem_write      (mem_write),
    .mem_refresh    (mem_refresh),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata)
  );

endmodule

//--- test/tb_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// 20 ns clock, reset held low for the first 4 rising edges
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic sys_resetn
);

  initial begin
    clk        = 1'b0;
    sys_resetn = 1'b0;
    forever #10 clk = !clk;
  end

  initial begin
    repeat (4) @(posedge clk);
    sys_resetn <= 1'b1;  // released on the 4th edge
  end

endmodule

//--- test/nes_glue_checker.sv
////////////////////////////////////////////////////////////////////////////
// phase rules of the arbiter, bound into every nes_phase_arbiter
// silent while sys_resetn is low
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module nes_glue_checker (
  input logic clk,
  input logic sys_resetn,
  input logic loader_done,
  input logic loader_write,
  input logic nes_run,
  input logic mem_read_a,
  input logic mem_read_b,
  input logic mem_write
);

  logic nes_mem_cmd;  // command that came from the console

  assign nes_mem_cmd = mem_read_a || mem_read_b || (mem_write && !loader_write);

  run_without_cmd: assert property (@(posedge clk) disable iff (!sys_resetn)
    !(nes_run && nes_mem_cmd))
    else $error("console memory command in the same cycle as nes_run");

  run_gap: assert property (@(posedge clk) disable iff (!sys_resetn)
    nes_run |=> !nes_run [*4])
    else $error("nes_run repeated within five cycles");

  run_period: assert property (@(posedge clk) disable iff (!sys_resetn)
    nes_run ##1 loader_done [*5] |-> nes_run)
    else $error("nes_run missing five cycles after the last one");

  write_slot: assert property (@(posedge clk) disable iff (!sys_resetn)
    (mem_write && !loader_write) |-> $past(nes_run))
    else $error("console write outside the cycle after nes_run");

endmodule

bind nes_phase_arbiter nes_glue_checker u_checker (.*);

//--- test/nes_glue_tb.sv
////////////////////////////////////////////////////////////////////////////
// table driven testbench for nes_glue_top with an autofire half period of 4
// inputs change on the rising edge and outputs are checked on the falling one
// controller bytes come from a 32 bit LFSR with a fixed seed
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module nes_glue_tb import nes_glue_pkg::*;;

  localparam int AF_HALF  = 4;
  localparam int DEC_ROWS = 6;
  localparam int MAP_ROWS = 8;
  localparam int AF_ROWS  = 6;
  localparam int ARB_ROWS = 10;

  typedef struct {
    logic [7:0] addr;
    logic [7:0] data;
    logic       valid;
    logic       reset;  // loader_reset after the write
  } dec_row_t;

  typedef struct {
    int len;
    logic done, rd_cpu, rd_ppu, wr, lw, lref;
  } arb_row_t;

  logic clk, sys_resetn;
  logic [7:0] uart_data, uart_addr;
  logic uart_write, loader_done, loader_write, loader_refresh;
  mem_addr_t loader_addr, nes_addr, mem_addr;
  logic [7:0] loader_wdata, nes_wdata, mem_wdata;
  logic [7:0] ds1_b0, ds1_b1, ds2_b0, ds2_b1, usb1_btn, usb2_btn;
  logic usb1_x, usb1_y, usb2_x, usb2_y;
  logic joypad_strobe, nes_read_cpu, nes_read_ppu, nes_write;
  logic [1:0] joypad_clock, joypad_data;
  logic [7:0] loader_byte;
  logic loader_byte_valid, loader_reset, nes_run, nes_reset;
  logic mem_read_a, mem_read_b, mem_write, mem_refresh;

  dec_row_t   dec_tab [DEC_ROWS];
  arb_row_t   arb_tab [ARB_ROWS];
  int         af_len  [AF_ROWS];
  logic [7:0] af_b1   [AF_ROWS];
  logic [7:0] map_b0 [2][MAP_ROWS], map_b1 [2][MAP_ROWS];
  logic [7:0] map_usb [2][MAP_ROWS], map_rem [2][MAP_ROWS], map_exp [2][MAP_ROWS];

  logic [31:0] lfsr_state = 32'h8735;
  int checks = 0;
  int errors = 0;
  int wd_cycles;
  logic [2:0] m_phase;  // reference phase
  logic af_out;
  int af_cnt;
  logic exp_bit;

  tb_clock_gen u_clk (.clk(clk), .sys_resetn(sys_resetn));

  nes_glue_top #(.AUTOFIRE_HALF(AF_HALF)) u_dut (.*);

  always @(posedge clk) begin
    if (!sys_resetn) m_phase <= 3'd0;
    else m_phase <= (m_phase == 3'd4) ? 3'd0 : m_phase + 3'd1;
  end

  // taps 32 22 2 1, one step per bit
  function automatic logic [7:0] rand_byte();
    logic fb;
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < 8; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[6:0], fb};
    end
    return r;
  endfunction

  // NES order from active low DualShock bytes plus the active high sources
  function automatic logic [7:0] expected_buttons(input logic [7:0] b0, b1, usb, rem,
                                                  input logic fa, fb);
    logic [7:0] r;
    r[0] = !b1[5] || fa;  // circle
    r[1] = !b1[6] || fb;  // cross
    r[2] = !b0[0];
    r[3] = !b0[3];
    r[4] = !b0[4];
    r[5] = !b0[6];
    r[6] = !b0[7];
    r[7] = !b0[5];
    return r | usb | rem;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, data);
    @(posedge clk);
    uart_write <= 1'b1;
    uart_addr  <= addr;
    uart_data  <= data;
  endtask

  initial begin
    uart_data      = '0;
    uart_addr      = '0;
    uart_write     = 0;
    loader_done    = 0;
    loader_write   = 0;
    loader_refresh = 0;
    loader_addr    = '0;
    loader_wdata   = '0;
    nes_addr       = '0;
    nes_wdata      = '0;
    ds1_b0         = 8'hff;
    ds1_b1         = 8'hff;
    ds2_b0         = 8'hff;
    ds2_b1         = 8'hff;
    usb1_btn       = '0;
    usb2_btn       = '0;
    usb1_x         = 0;
    usb1_y         = 0;
    usb2_x         = 0;
    usb2_y         = 0;
    joypad_strobe  = 0;
    joypad_clock   = '0;
    nes_read_cpu   = 0;
    nes_read_ppu   = 0;
    nes_write      = 0;

    dec_tab[0] = '{8'h37, 8'ha5, 1'b1, 1'b0};
    dec_tab[1] = '{8'h40, 8'h00, 1'b0, 1'b0};
    dec_tab[2] = '{8'h35, 8'h01, 1'b0, 1'b1};
    dec_tab[3] = '{8'h37, 8'h3c, 1'b1, 1'b1};
    dec_tab[4] = '{8'h35, 8'h00, 1'b0, 1'b0};
    dec_tab[5] = '{8'h41, 8'h00, 1'b0, 1'b0};

    // triangle and square stay released so autofire is quiet
    for (int r = 0; r < MAP_ROWS; r++) begin
      for (int p = 0; p < 2; p++) begin
        map_b0[p][r]  = rand_byte();
        map_b1[p][r]  = rand_byte() | 8'h90;
        map_usb[p][r] = rand_byte() & rand_byte();
        map_rem[p][r] = rand_byte() & rand_byte() & rand_byte();
        map_exp[p][r] = expected_buttons(map_b0[p][r], map_b1[p][r],
                                         map_usb[p][r], map_rem[p][r], 1'b0, 1'b0);
      end
    end

    af_len = '{22, 3, 13, 4, 6, 4};
    af_b1  = '{8'hef, 8'hff, 8'hef, 8'hdf, 8'hcf, 8'hff};

    arb_tab[0] = '{10, 0, 1, 0, 0, 0, 0};
    arb_tab[1] = '{5,  0, 0, 0, 1, 0, 0};
    arb_tab[2] = '{10, 1, 0, 0, 0, 0, 0};
    arb_tab[3] = '{10, 1, 1, 0, 0, 0, 0};
    arb_tab[4] = '{5,  1, 0, 1, 0, 0, 0};
    arb_tab[5] = '{10, 1, 0, 0, 1, 0, 0};
    arb_tab[6] = '{7,  1, 0, 0, 1, 1, 0};
    arb_tab[7] = '{5,  1, 0, 0, 0, 0, 1};
    arb_tab[8] = '{5,  1, 0, 0, 0, 1, 1};
    arb_tab[9] = '{3,  0, 0, 0, 0, 1, 0};

    // about 2 cycles per decode row and 45 per mapping row plus the listed cycles
    wd_cycles = DEC_ROWS * 2 + MAP_ROWS * 45 + 20;
    foreach (af_len[i]) wd_cycles += af_len[i];
    foreach (arb_tab[i]) wd_cycles += arb_tab[i].len;
    wd_cycles = wd_cycles * 5 + 200;
    fork
      begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: simulation did not finish in %0d cycles", wd_cycles);
        $display("TESTS FAILED");
        $finish;
      end
    join_none

    wait (sys_resetn === 1'b1);

    for (int i = 0; i < DEC_ROWS; i++) begin
      write_reg(dec_tab[i].addr, dec_tab[i].data);
      @(negedge clk);
      check_val("loader_byte_valid", loader_byte_valid, dec_tab[i].valid);
      if (dec_tab[i].valid) check_val("loader_byte", loader_byte, dec_tab[i].data);
      @(posedge clk);
      uart_write <= 1'b0;
      @(negedge clk);
      check_val("loader_reset", loader_reset, dec_tab[i].reset);
    end

    for (int r = 0; r < MAP_ROWS; r++) begin
      write_reg(8'h40, map_rem[0][r]);
      ds1_b0   <= map_b0[0][r];
      ds1_b1   <= map_b1[0][r];
      usb1_btn <= map_usb[0][r];
      ds2_b0   <= map_b0[1][r];
      ds2_b1   <= map_b1[1][r];
      usb2_btn <= map_usb[1][r];
      write_reg(8'h41, map_rem[1][r]);
      @(posedge clk);
      uart_write <= 1'b0;
      @(posedge clk);
      joypad_strobe <= 1'b1;
      @(posedge clk);
      joypad_strobe <= 1'b0;  // latch loads on this edge
      for (int b = 0; b <= 8; b++) begin
        @(negedge clk);
        check_val("joypad_data[0]", joypad_data[0], (b < 8) ? map_exp[0][r][b] : 1'b0);
        check_val("joypad_data[1]", joypad_data[1], (b < 8) ? map_exp[1][r][b] : 1'b0);
        if (b < 8) begin
          @(posedge clk);
          joypad_clock <= 2'b11;
          @(posedge clk);
          joypad_clock <= 2'b00;
          repeat (2) @(posedge clk);  // edge detect, then shift
        end
      end
    end

    // autofire on player 1, latch kept transparent by a held strobe
    write_reg(8'h40, 8'h00);
    ds1_b0   <= 8'hff;
    ds1_b1   <= 8'hff;
    usb1_btn <= 8'h00;
    @(posedge clk);
    uart_write    <= 1'b0;
    joypad_strobe <= 1'b1;
    repeat (3) @(posedge clk);
    af_out = 1'b0;
    af_cnt = 0;
    for (int r = 0; r < AF_ROWS; r++) begin
      for (int c = 0; c < af_len[r]; c++) begin
        @(posedge clk);
        exp_bit = !ds1_b1[5] || af_out;
        if (ds1_b1[4]) begin
          af_cnt = 0;
          af_out = 1'b0;
        end else if (af_cnt == AF_HALF - 1) begin
          af_cnt = 0;
          af_out = !af_out;
        end else begin
          af_cnt++;
        end
        ds1_b1 <= af_b1[r];
        @(negedge clk);
        check_val("joypad_data[0]", joypad_data[0], exp_bit);
      end
    end
    @(posedge clk);
    joypad_strobe <= 1'b0;

    for (int r = 0; r < ARB_ROWS; r++) begin
      for (int c = 0; c < arb_tab[r].len; c++) begin
        @(posedge clk);
        loader_done    <= arb_tab[r].done;
        nes_read_cpu   <= arb_tab[r].rd_cpu;
        nes_read_ppu   <= arb_tab[r].rd_ppu;
        nes_write      <= arb_tab[r].wr;
        loader_write   <= arb_tab[r].lw;
        loader_refresh <= arb_tab[r].lref;
        nes_addr       <= 22'h100000 + 22'(r);
        loader_addr    <= 22'h2a0000 + 22'(r * 3);
        nes_wdata      <= 8'h10 + 8'(r);
        loader_wdata   <= 8'hc0 + 8'(r);
        @(negedge clk);
        begin
          logic slot;
          slot = (m_phase == 3'd0) && arb_tab[r].done;
          check_val("nes_run", nes_run, (m_phase == 3'd4) && arb_tab[r].done);
          check_val("nes_reset", nes_reset, !arb_tab[r].done);
          check_val("mem_read_a", mem_read_a, slot && arb_tab[r].rd_cpu);
          check_val("mem_read_b", mem_read_b, slot && arb_tab[r].rd_ppu);
          check_val("mem_write", mem_write, (slot && arb_tab[r].wr) || arb_tab[r].lw);
          check_val("mem_refresh", mem_refresh,
                    (slot && !arb_tab[r].rd_cpu && !arb_tab[r].rd_ppu && !arb_tab[r].wr
                     && !arb_tab[r].lw) || (arb_tab[r].lref && !arb_tab[r].lw));
          check_val("mem_addr", mem_addr, arb_tab[r].lw ? 22'h2a0000 + r * 3 : 22'h100000 + r);
          check_val("mem_wdata", mem_wdata, arb_tab[r].lw ? 8'hc0 + r : 8'h10 + r);
        end
      end
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
hdl/nes_glue_pkg.sv
hdl/uart_reg_decoder.sv
hdl/autofire.sv
hdl/pad_mapper.sv
hdl/joypad_shift.sv
hdl/nes_phase_arbiter.sv
hdl/nes_glue_top.sv
test/tb_clock_gen.sv
test/nes_glue_checker.sv
test/nes_glue_tb.sv

//--- Makefile
# Verilator build for the NES glue testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile: obj_dir/Vnes_glue_tb

obj_dir/Vnes_glue_tb: build.f $(wildcard hdl/*.sv test/*.sv)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module nes_glue_tb -f build.f -o Vnes_glue_tb

run: compile
	./obj_dir/Vnes_glue_tb | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
